/* source/bus_pkg.sv */
package bus_pkg;

	// ------------------------------------------------------------
	// widths of the node request channel
	// ------------------------------------------------------------
	localparam int unsigned ADDR_W = 32;
	localparam int unsigned DATA_W = 32;
	localparam int unsigned SEL_W  = DATA_W / 8;	// one select per byte lane

	// request from the node bus master
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [SEL_W-1:0]  sel;
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat;	// write data
	} io_req_t;

	// response back toward the master
	// dat is zero whenever ack is low so responses can be ORed together
	typedef struct packed {
		logic              ack;
		logic [DATA_W-1:0] dat;
	} io_resp_t;

endpackage

/* source/io_map_pkg.sv */
package io_map_pkg;

	// ------------------------------------------------------------
	// scratch memory region
	// ------------------------------------------------------------
	localparam int unsigned SCR_REGION_LSB = 20;	// region compare on adr[31:20]
	localparam logic [11:0] SCR_REGION     = 12'h001;
	localparam int unsigned SCR_WORDS      = 1024;
	localparam int unsigned SCR_IDX_W      = $clog2(SCR_WORDS);	// word index from adr[11:2]

	// ------------------------------------------------------------
	// peripheral regions, 256 bytes each
	// ------------------------------------------------------------
	localparam int unsigned IO_REGION_LSB = 8;	// region compare on adr[31:8]
	localparam int unsigned OFS_W         = 8;
	localparam logic [23:0] LED_REGION    = 24'hFD0FFF;
	localparam logic [23:0] RAND_REGION   = 24'hFD0FFD;

	// generator register offsets
	localparam logic [OFS_W-1:0] RAND_VALUE_OFS = 8'h00;
	localparam logic [OFS_W-1:0] RAND_SEED_OFS  = 8'h04;

	// galois lfsr, shift right
	localparam logic [31:0] LFSR_TAPS       = 32'h80200003;
	localparam logic [31:0] LFSR_RESET_SEED = 32'h00000001;	// also replaces a zero seed

	localparam int unsigned LED_W = 8;

endpackage

/* source/scratch_branch.sv */
`timescale 1ns/100ps

module scratch_branch
	import bus_pkg::*;
	import io_map_pkg::*;
(
	input  logic     node_clk,
	input  logic     rst,
	input  io_req_t  req_i,
	output io_resp_t resp_o
);

	logic [DATA_W-1:0] mem [SCR_WORDS];

	logic                 hit;
	logic                 take;
	logic                 pending;	// strobe already answered
	logic                 ack_q;
	logic [DATA_W-1:0]    rd_q;
	logic [SCR_IDX_W-1:0] idx;

	// ------------------------------------------------------------
	// region decode
	// ------------------------------------------------------------
	assign hit  = req_i.cyc && req_i.stb &&
		(req_i.adr[ADDR_W-1:SCR_REGION_LSB] == SCR_REGION);
	assign take = hit && !pending;
	assign idx  = req_i.adr[SCR_IDX_W+1:2];

	// ------------------------------------------------------------
	// memory array, byte lane writes
	// ------------------------------------------------------------
	always_ff @(posedge node_clk) begin
		if (take) begin
			if (req_i.we) begin
				for (int b = 0; b < SEL_W; b++) begin
					if (req_i.sel[b])
						mem[idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
				end
				rd_q <= '0;	// writes return no data
			end else begin
				rd_q <= mem[idx];
			end
		end
	end

	// one ack per strobe
	always_ff @(posedge node_clk) begin
		if (rst) begin
			ack_q   <= 1'b0;
			pending <= 1'b0;
		end else begin
			ack_q <= take;
			if (!req_i.stb)
				pending <= 1'b0;	// master released strobe
			else if (take)
				pending <= 1'b1;
		end
	end

	// data only while acknowledging, keeps the merge OR clean
	assign resp_o = '{ack: ack_q, dat: ack_q ? rd_q : '0};

endmodule

/* source/periph_branch.sv */
`timescale 1ns/100ps

module periph_branch
	import bus_pkg::*;
	import io_map_pkg::*;
(
	input  logic             node_clk,
	input  logic             rst,
	input  io_req_t          req_i,
	output io_resp_t         resp_o,
	output logic [LED_W-1:0] led_o
);

	logic              led_hit;
	logic              rand_hit;
	logic              take;
	logic              pending;
	logic              ack_q;
	logic [DATA_W-1:0] rd_q;
	logic [DATA_W-1:0] rd_d;
	logic [OFS_W-1:0]  ofs;
	logic [LED_W-1:0]  led_q;
	logic [31:0]       lfsr;
	logic [31:0]       lfsr_next;

	// ------------------------------------------------------------
	// decode
	// ------------------------------------------------------------
	assign led_hit  = req_i.cyc && req_i.stb &&
		(req_i.adr[ADDR_W-1:IO_REGION_LSB] == LED_REGION);
	assign rand_hit = req_i.cyc && req_i.stb &&
		(req_i.adr[ADDR_W-1:IO_REGION_LSB] == RAND_REGION);
	assign take     = (led_hit || rand_hit) && !pending;
	assign ofs      = req_i.adr[OFS_W-1:0];

	// galois step, taps applied when a one falls out
	assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);

	// read mux, seed register reads back as zero
	always_comb begin
		rd_d = '0;
		if (led_hit)
			rd_d = {{(DATA_W-LED_W){1'b0}}, led_q};
		else if (rand_hit && ofs == RAND_VALUE_OFS)
			rd_d = lfsr;
	end

	// ------------------------------------------------------------
	// registers
	// ------------------------------------------------------------
	always_ff @(posedge node_clk) begin
		if (rst) begin
			led_q <= '0;
			lfsr  <= LFSR_RESET_SEED;
		end else if (take) begin
			if (led_hit && req_i.we)
				led_q <= req_i.dat[LED_W-1:0];
			if (rand_hit && req_i.we && ofs == RAND_SEED_OFS)
				lfsr <= (req_i.dat == '0) ? LFSR_RESET_SEED : req_i.dat;
			else if (rand_hit && !req_i.we && ofs == RAND_VALUE_OFS)
				lfsr <= lfsr_next;	// advance after each value read
		end
	end

	// ------------------------------------------------------------
	// bridge response stage
	// ------------------------------------------------------------
	always_ff @(posedge node_clk) begin
		if (rst) begin
			ack_q   <= 1'b0;
			pending <= 1'b0;
		end else begin
			ack_q <= take;
			if (!req_i.stb)
				pending <= 1'b0;
			else if (take)
				pending <= 1'b1;	// hold off until strobe drops
		end
	end

	always_ff @(posedge node_clk) begin
		if (take)
			rd_q <= req_i.we ? '0 : rd_d;
	end

	assign resp_o = '{ack: ack_q, dat: ack_q ? rd_q : '0};
	assign led_o  = led_q;

endmodule

/* source/resp_merge.sv */
`timescale 1ns/100ps

module resp_merge
	import bus_pkg::*;
(
	input  logic     node_clk,
	input  logic     rst,
	input  io_resp_t scr_resp_i,
	input  io_resp_t per_resp_i,
	output io_resp_t resp_o
);

	logic              ack_q;
	logic [DATA_W-1:0] dat_q;

	// ------------------------------------------------------------
	// wired-or of the branch responses, one register stage
	// ------------------------------------------------------------
	always_ff @(posedge node_clk) begin
		if (rst)
			ack_q <= 1'b0;
		else
			ack_q <= scr_resp_i.ack | per_resp_i.ack;
	end

	// idle branches drive zero data
	always_ff @(posedge node_clk) begin
		dat_q <= scr_resp_i.dat | per_resp_i.dat;
	end

	assign resp_o = '{ack: ack_q, dat: dat_q};

endmodule

/* source/io_fabric.sv */
`timescale 1ns/100ps

module io_fabric
	import bus_pkg::*;
	import io_map_pkg::*;
(
	input  logic             node_clk,
	input  logic             rst,
	input  io_req_t          req_i,
	output io_resp_t         resp_o,
	output logic [LED_W-1:0] led_o
);

	io_resp_t scr_resp;
	io_resp_t per_resp;

	// ------------------------------------------------------------
	// branches see the same request and decode for themselves
	// ------------------------------------------------------------
	scratch_branch i_scratch (
		.node_clk (node_clk),
		.rst      (rst),
		.req_i    (req_i),
		.resp_o   (scr_resp)
	);

	periph_branch i_periph (
		.node_clk (node_clk),
		.rst      (rst),
		.req_i    (req_i),
		.resp_o   (per_resp),
		.led_o    (led_o)
	);

	resp_merge i_merge (
		.node_clk   (node_clk),
		.rst        (rst),
		.scr_resp_i (scr_resp),
		.per_resp_i (per_resp),
		.resp_o     (resp_o)
	);

endmodule

/* verification/io_fabric_props.sv */
`timescale 1ns/100ps

module io_fabric_props
	import bus_pkg::*;
(
	input logic     node_clk,
	input logic     rst,
	input io_resp_t scr_resp_i,
	input io_resp_t per_resp_i,
	input io_resp_t merged_i
);

	// ------------------------------------------------------------
	// merged response checks
	// ------------------------------------------------------------
	a_single_ack: assert property (@(posedge node_clk) disable iff (rst)
		merged_i.ack |=> !merged_i.ack)
		else $error("resp_o.ack high in two consecutive cycles");

	// regions never overlap
	a_branch_excl: assert property (@(posedge node_clk) disable iff (rst)
		!(scr_resp_i.ack && per_resp_i.ack))
		else $error("scratch and peripheral acks high together");

	a_reset_ack: assert property (@(posedge node_clk)
		rst |=> !merged_i.ack)	// first cycle after reset
		else $error("resp_o.ack high right after reset");

endmodule

bind resp_merge io_fabric_props i_props (
	.node_clk   (node_clk),
	.rst        (rst),
	.scr_resp_i (scr_resp_i),
	.per_resp_i (per_resp_i),
	.merged_i   (resp_o)
);

/* verification/io_fabric_tb.sv */
`timescale 1ns/100ps

module io_fabric_tb
	import bus_pkg::*;
	import io_map_pkg::*;
();

	localparam int CLK_PERIOD    = 100;
	localparam int RST_CYCLES    = 5;
	localparam int ACK_LATENCY   = 2;	// strobe sample edge to merged ack
	localparam int ACK_LIMIT     = 8;
	localparam int CYCLES_PER_OP = 10;	// watchdog budget per table entry

	typedef enum logic [2:0] {OP_WR, OP_RD, OP_LED_WR, OP_RAND_RD, OP_SEED_WR} op_t;

	typedef struct {
		string       name;
		op_t         op;
		logic [31:0] adr;
		logic [3:0]  sel;
		logic [31:0] dat;
		logic [31:0] exp;	// read data, or led_o after an LED write
		int          hold;	// extra cycles stb stays up after the ack
	} test_t;

	logic             node_clk;
	logic             rst;
	io_req_t          req;
	io_resp_t         resp_o;
	logic [LED_W-1:0] led_o;

	test_t       tests[$];
	bit          table_ready = 1'b0;
	int          errors = 0;
	int          failed_tests = 0;
	integer      seed = 90898;
	logic [31:0] lfsr_model;	// expected generator state

	io_fabric i_dut (
		.node_clk (node_clk),
		.rst      (rst),
		.req_i    (req),
		.resp_o   (resp_o),
		.led_o    (led_o)
	);

	initial begin
		node_clk = 1'b0;
		forever #(CLK_PERIOD/2) node_clk = ~node_clk;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic check(input string sig, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("** Error at %0d ns: %s expected 0x%08h, got 0x%08h", $time, sig, exp, act);
			errors++;
		end
	endtask

	// shift right and apply the taps when a one drops out
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] shifted;
		shifted = s >> 1;
		if (s[0])
			shifted = shifted ^ LFSR_TAPS;
		return shifted;
	endfunction

	task automatic add_test(input string name, input op_t op, input logic [31:0] adr,
		input logic [3:0] sel, input logic [31:0] dat, input logic [31:0] exp, input int hold);
		test_t t;
		t.name = name;
		t.op   = op;
		t.adr  = adr;
		t.sel  = sel;
		t.dat  = dat;
		t.exp  = exp;
		t.hold = hold;
		tests.push_back(t);
	endtask

	task automatic build_table();
		logic [31:0] rnd_seed;
		rnd_seed = $random(seed);
		// full-width scratch words
		add_test("scr_wr_0",   OP_WR, 32'h0010_0000, 4'hF, 32'hDEAD_BEEF, 32'h0, 0);
		add_test("scr_wr_1",   OP_WR, 32'h0010_0004, 4'hF, 32'h0123_4567, 32'h0, 3);
		add_test("scr_wr_2",   OP_WR, 32'h0010_0FFC, 4'hF, 32'hCAFE_F00D, 32'h0, 1);
		add_test("scr_rd_0",   OP_RD, 32'h0010_0000, 4'hF, 32'h0, 32'hDEAD_BEEF, 0);
		add_test("scr_rd_1",   OP_RD, 32'h0010_0004, 4'hF, 32'h0, 32'h0123_4567, 2);
		add_test("scr_rd_2",   OP_RD, 32'h0010_0FFC, 4'hF, 32'h0, 32'hCAFE_F00D, 0);
		// byte lanes merge into the old word
		add_test("byte_base",  OP_WR, 32'h0010_0010, 4'hF, 32'h1122_3344, 32'h0, 0);
		add_test("byte_lane1", OP_WR, 32'h0010_0010, 4'h2, 32'hAABB_CCDD, 32'h0, 0);
		add_test("byte_l3_l0", OP_WR, 32'h0010_0010, 4'h9, 32'h5566_7788, 32'h0, 1);
		add_test("byte_rd",    OP_RD, 32'h0010_0010, 4'hF, 32'h0, 32'h5522_CC88, 0);
		// led register
		add_test("led_wr",     OP_LED_WR, 32'hFD0F_FF00, 4'hF, 32'h1234_56A5, 32'hA5, 0);
		add_test("led_rd",     OP_RD, 32'hFD0F_FF00, 4'hF, 32'h0, 32'h0000_00A5, 2);
		// generator straight out of reset
		add_test("rand_rd_0",  OP_RAND_RD, 32'hFD0F_FD00, 4'hF, 32'h0, 32'h0, 0);
		add_test("rand_rd_1",  OP_RAND_RD, 32'hFD0F_FD00, 4'hF, 32'h0, 32'h0, 3);
		add_test("rand_rd_2",  OP_RAND_RD, 32'hFD0F_FD00, 4'hF, 32'h0, 32'h0, 0);
		add_test("rand_rd_3",  OP_RAND_RD, 32'hFD0F_FD00, 4'hF, 32'h0, 32'h0, 1);
		add_test("seed_rnd",   OP_SEED_WR, 32'hFD0F_FD04, 4'hF, rnd_seed, 32'h0, 0);
		add_test("rand_rd_4",  OP_RAND_RD, 32'hFD0F_FD00, 4'hF, 32'h0, 32'h0, 0);
		add_test("rand_rd_5",  OP_RAND_RD, 32'hFD0F_FD00, 4'hF, 32'h0, 32'h0, 2);
		add_test("seed_rd",    OP_RD, 32'hFD0F_FD04, 4'hF, 32'h0, 32'h0, 0);
		add_test("seed_zero",  OP_SEED_WR, 32'hFD0F_FD04, 4'hF, 32'h0, 32'h0, 1);
		add_test("rand_rd_6",  OP_RAND_RD, 32'hFD0F_FD00, 4'hF, 32'h0, 32'h0, 0);
		add_test("rand_rd_7",  OP_RAND_RD, 32'hFD0F_FD00, 4'hF, 32'h0, 32'h0, 0);
		add_test("led_wr_2",   OP_LED_WR, 32'hFD0F_FF00, 4'hF, 32'h0000_005A, 32'h5A, 3);
	endtask

	// ------------------------------------------------------------
	// one bus access with latency and single-ack checks
	// ------------------------------------------------------------
	task automatic run_test(input test_t t);
		int          cycles;
		int          extra_acks;
		bit          got_ack;
		logic [31:0] exp_dat;
		logic [31:0] ack_dat;
		case (t.op)
			OP_RD:      exp_dat = t.exp;
			OP_RAND_RD: exp_dat = lfsr_model;
			default:    exp_dat = '0;	// writes answer with zero data
		endcase
		@(negedge node_clk);
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = (t.op inside {OP_WR, OP_LED_WR, OP_SEED_WR});
		req.sel = t.sel;
		req.adr = t.adr;
		req.dat = t.dat;
		cycles  = 0;
		got_ack = 1'b0;
		ack_dat = '0;
		while (!got_ack && cycles < ACK_LIMIT) begin
			@(negedge node_clk);
			cycles++;
			if (resp_o.ack) begin
				got_ack = 1'b1;
				ack_dat = resp_o.dat;
			end
		end
		if (!got_ack) begin
			$display("%s: no acknowledge within %0d cycles of the strobe", t.name, ACK_LIMIT);
			errors++;
		end else begin
			check("resp_o.ack latency", ACK_LATENCY, cycles);
			check("resp_o.dat", exp_dat, ack_dat);
		end
		extra_acks = 0;
		repeat (t.hold) begin
			@(negedge node_clk);
			if (resp_o.ack)
				extra_acks++;
		end
		req = '0;
		@(negedge node_clk);
		if (resp_o.ack)
			extra_acks++;
		check("resp_o.ack extra", 0, extra_acks);
		if (t.op == OP_LED_WR)
			check("led_o", t.exp, {24'b0, led_o});
		if (t.op == OP_RAND_RD)
			lfsr_model = lfsr_step(lfsr_model);
		if (t.op == OP_SEED_WR)
			lfsr_model = (t.dat == 32'h0) ? LFSR_RESET_SEED : t.dat;
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("%-12s ok", name);
		end else begin
			$display("%-12s FAILED", name);
			failed_tests++;
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		int errors_before;
		req        = '0;
		rst        = 1'b1;
		lfsr_model = LFSR_RESET_SEED;
		build_table();
		table_ready = 1'b1;
		repeat (RST_CYCLES) @(posedge node_clk);
		@(negedge node_clk);
		rst = 1'b0;
		errors_before = errors;
		check("resp_o.ack", 32'h0, {31'b0, resp_o.ack});
		check("led_o", 32'h0, {24'b0, led_o});
		report_test("reset", errors_before);
		foreach (tests[i]) begin
			errors_before = errors;
			run_test(tests[i]);
			report_test(tests[i].name, errors_before);
		end
		$display("%0d tests, %0d failed, %0d errors", tests.size() + 1, failed_tests, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// watchdog sized from the table
	initial begin
		int limit;
		wait (table_ready);
		limit = tests.size() * CYCLES_PER_OP + RST_CYCLES;
		repeat (limit) @(posedge node_clk);
		$display("timeout: tests did not finish within %0d cycles", limit);
		$display("Regression failed");
		$finish;
	end

endmodule

/* list.f */
source/bus_pkg.sv
source/io_map_pkg.sv
source/scratch_branch.sv
source/periph_branch.sv
source/resp_merge.sv
source/io_fabric.sv
verification/io_fabric_props.sv
verification/io_fabric_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = io_fabric_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
FAIL_MSG = Regression failed
PASS_MSG = Regression passed
SRCS     = $(wildcard source/*.sv) $(wildcard verification/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
